/* Makefile */
# Verilator build and run for the alu_core testbench

VERILATOR ?= verilator
TOP       ?= alu_core_tb
FILELIST  ?= alu_core.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
EXTRA     ?=

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a failing check ends in $$fatal, so the exit status carries the result
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* alu_core.f */
logic/core_pkg.sv
logic/stage_reg.sv
logic/reg_file.sv
logic/instr_decode.sv
logic/alu_execute.sv
logic/write_back.sv
logic/alu_core.sv
bench/alu_core_tb.sv

/* bench/alu_core_tb.sv */
`timescale 1ns/10ps

module alu_core_tb;

    localparam core_pkg::xlen_t RESET_PC    = 32'h8000_0000;
    localparam int              DRIVE_DLY   = 1;
    localparam int              DRAIN_LIMIT = 50;

    logic              clk;
    logic              resetn;
    logic              instr_valid_i;
    core_pkg::xlen_t   instr_i;
    core_pkg::commit_t commit;

    core_pkg::xlen_t   model_regs [32];
    core_pkg::xlen_t   next_pc;
    core_pkg::commit_t exp_q [$];
    int                edge_q [$];
    int                edge_cnt = 0;
    logic [31:0]       lcg_state = 32'd65;
    logic [6:0]        bad_opc [6] = '{7'h03, 7'h23, 7'h63, 7'h6F, 7'h73, 7'h0F};

    alu_core #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk           (clk),
        .resetn        (resetn),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .commit_o      (commit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // ==============================
    // random numbers and encoders
    // ==============================
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (next_rand() >> 16) % n;
    endfunction

    function automatic core_pkg::xlen_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic core_pkg::xlen_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    function automatic core_pkg::xlen_t u_word(input logic [6:0] opc, input logic [19:0] imm,
                                               input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    function automatic core_pkg::xlen_t random_word();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        f3  = 3'(rand_below(8));
        rd  = 5'(rand_below(8));
        rs1 = 5'(rand_below(8));
        rs2 = 5'(rand_below(8));
        imm = 12'(next_rand() >> 7);
        case (rand_below(11))
            0, 1, 2: begin
                if ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) begin
                    return r_word(7'h20, rs2, rs1, f3, rd);
                end
                return r_word(7'h00, rs2, rs1, f3, rd);
            end
            3, 4, 5: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm[11:5] = (f3 == 3'd5 && rand_below(2) == 1) ? 7'h20 : 7'h00;
                end
                return i_word(imm, rs1, f3, rd);
            end
            6: return u_word(7'h37, 20'(next_rand() >> 3), rd);
            7: return u_word(7'h17, 20'(next_rand() >> 3), rd);
            8: return r_word(7'h01, rs2, rs1, f3, rd);
            9: return i_word({7'h10, imm[4:0]}, rs1, 3'd5, rd);
            default: return {25'(next_rand()), bad_opc[rand_below(6)]};
        endcase
    endfunction

    // ==============================
    // reference model
    // ==============================
    function automatic core_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                                input core_pkg::xlen_t a,
                                                input core_pkg::xlen_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                // kept apart so the arithmetic shift stays signed
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic core_pkg::commit_t model_commit(input core_pkg::xlen_t w,
                                                       input core_pkg::xlen_t pc);
        core_pkg::commit_t c;
        core_pkg::xlen_t   a;
        core_pkg::xlen_t   val;
        logic              bad_f7;
        c      = '0;
        c.en   = 1'b1;
        c.pc   = pc;
        a      = model_regs[w[19:15]];
        val    = '0;
        bad_f7 = (w[31:25] != 7'h00) && (w[31:25] != 7'h20);
        case (w[6:0])
            7'h33: begin
                c.illegal = bad_f7;
                val       = alu_ref(w[14:12], w[30], a, model_regs[w[24:20]]);
            end
            7'h13: begin
                // slli and srli/srai
                c.illegal = bad_f7 && (w[13:12] == 2'b01);
                val       = alu_ref(w[14:12], w[30] && (w[14:12] == 3'd5), a,
                                    {{20{w[31]}}, w[31:20]});
            end
            7'h37: val = {w[31:12], 12'h000};
            7'h17: val = pc + {w[31:12], 12'h000};
            default: c.illegal = 1'b1;
        endcase
        if (!c.illegal) begin
            c.rd = w[11:7];
            if (c.rd != 5'd0) begin
                c.data         = val;
                model_regs[c.rd] = val;
            end
        end
        return c;
    endfunction

    // ==============================
    // checks
    // ==============================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input core_pkg::xlen_t got,
                              input core_pkg::xlen_t want);
        if (got !== want) begin
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_reg_idx(input string name, input core_pkg::reg_idx_t got,
                                 input core_pkg::reg_idx_t want);
        if (got !== want) begin
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    // commit outputs are stable at the falling edge
    initial begin
        core_pkg::commit_t want;
        int                want_edge;
        forever begin
            @(negedge clk);
            if (resetn === 1'b1) begin
                if (commit.en === 1'b1) begin
                    if (exp_q.size() == 0) begin
                        fail_run("a commit appeared with no instruction in flight");
                    end else begin
                        want      = exp_q.pop_front();
                        want_edge = edge_q.pop_front();
                        if (edge_cnt != want_edge) begin
                            fail_run($sformatf("commit for pc 0x%h came at edge %0d, not %0d",
                                               want.pc, edge_cnt, want_edge));
                        end
                        check_word("commit_o.pc", commit.pc, want.pc);
                        check_reg_idx("commit_o.rd", commit.rd, want.rd);
                        check_word("commit_o.data", commit.data, want.data);
                        check_flag("commit_o.illegal", commit.illegal, want.illegal);
                    end
                end else if (commit.en !== 1'b0) begin
                    fail_run("commit_o.en is unknown after reset");
                end else if (edge_q.size() != 0 && edge_cnt > edge_q[0]) begin
                    fail_run($sformatf("the commit for pc 0x%h never arrived", exp_q[0].pc));
                end
            end
        end
    end

    // ==============================
    // stimulus
    // ==============================
    task automatic issue(input core_pkg::xlen_t w);
        @(posedge clk);
        #DRIVE_DLY;
        instr_valid_i = 1'b1;
        instr_i       = w;
        exp_q.push_back(model_commit(w, next_pc));
        // accepted at the next edge, commit registered two edges after that
        edge_q.push_back(edge_cnt + 3);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
            instr_valid_i = 1'b0;
            instr_i       = next_rand();
        end
    endtask

    initial begin
        int waited;
        resetn        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        next_pc       = RESET_PC;
        waited        = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        resetn = 1'b1;
        idle(8);

        // operands: x1 negative, x2 = -3, x3 = 7
        issue(u_word(7'h37, 20'h80000, 5'd1));
        issue(i_word(12'h005, 5'd1, 3'd0, 5'd1));
        issue(i_word(12'hFFD, 5'd0, 3'd0, 5'd2));
        issue(i_word(12'h007, 5'd0, 3'd0, 5'd3));
        for (int f = 0; f < 8; f++) begin
            issue(r_word(7'h00, 5'd3, 5'd1, 3'(f), 5'd16));
            issue(r_word(7'h00, 5'd2, 5'd1, 3'(f), 5'd17));
            issue(i_word((f == 1 || f == 5) ? 12'h009 : 12'hF85, 5'd1, 3'(f), 5'd18));
        end
        issue(r_word(7'h20, 5'd3, 5'd1, 3'd0, 5'd19));
        issue(r_word(7'h20, 5'd3, 5'd1, 3'd5, 5'd19));
        issue(i_word({7'h20, 5'd9}, 5'd1, 3'd5, 5'd19));
        issue(u_word(7'h17, 20'h00123, 5'd20));
        idle(3);

        // dependency distances 1, 2 and 3 on x10
        issue(i_word(12'h064, 5'd0, 3'd0, 5'd10));
        issue(r_word(7'h00, 5'd10, 5'd10, 3'd0, 5'd11));
        issue(r_word(7'h00, 5'd10, 5'd11, 3'd0, 5'd12));
        issue(r_word(7'h00, 5'd11, 5'd10, 3'd0, 5'd13));

        // x0 writes, then illegal words aimed at x5
        issue(i_word(12'h07B, 5'd0, 3'd0, 5'd0));
        issue(r_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd5));
        issue(32'h0000_2283);
        issue(r_word(7'h01, 5'd3, 5'd1, 3'd0, 5'd5));
        issue(i_word({7'h10, 5'd3}, 5'd1, 3'd5, 5'd5));
        issue(r_word(7'h00, 5'd0, 5'd5, 3'd0, 5'd6));

        for (int n = 0; n < 400; n++) begin
            issue(random_word());
            if (rand_below(4) == 0) begin
                idle(1 + int'(rand_below(3)));
            end
        end
        idle(1);

        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            fail_run($sformatf("the commit for pc 0x%h never arrived", exp_q[0].pc));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* logic/alu_core.sv */
`timescale 1ns/10ps

module alu_core #(
    parameter core_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             instr_valid_i,
    input  core_pkg::xlen_t  instr_i,
    output core_pkg::commit_t commit_o
);

    core_pkg::reg_idx_t     rs1_idx;
    core_pkg::reg_idx_t     rs2_idx;
    core_pkg::xlen_t        rs1_data;
    core_pkg::xlen_t        rs2_data;
    core_pkg::decoded_t     decoded;
    logic                   ex_valid;
    core_pkg::decoded_t     ex_decoded;
    logic                   ex_res_valid;
    core_pkg::exec_result_t ex_result;
    logic                   wb_valid;
    core_pkg::exec_result_t wb_result;
    core_pkg::rf_write_t    rf_write;

    instr_decode #(
        .RESET_PC (RESET_PC)
    ) u_decode (
        .clk           (clk),
        .resetn        (resetn),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .decoded_o     (decoded)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .resetn     (resetn),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .write_i    (rf_write)
    );

    // decode to execute
    stage_reg #(
        .payload_t (core_pkg::decoded_t)
    ) u_de_reg (
        .clk       (clk),
        .resetn    (resetn),
        .valid_i   (instr_valid_i),
        .payload_i (decoded),
        .valid_o   (ex_valid),
        .payload_o (ex_decoded)
    );

    alu_execute u_execute (
        .valid_i   (ex_valid),
        .decoded_i (ex_decoded),
        .fwd_i     (rf_write),
        .valid_o   (ex_res_valid),
        .result_o  (ex_result)
    );

    // execute to write-back
    stage_reg #(
        .payload_t (core_pkg::exec_result_t)
    ) u_ew_reg (
        .clk       (clk),
        .resetn    (resetn),
        .valid_i   (ex_res_valid),
        .payload_i (ex_result),
        .valid_o   (wb_valid),
        .payload_o (wb_result)
    );

    write_back u_write_back (
        .clk        (clk),
        .resetn     (resetn),
        .valid_i    (wb_valid),
        .result_i   (wb_result),
        .rf_write_o (rf_write),
        .commit_o   (commit_o)
    );

endmodule

/* logic/alu_execute.sv */
`timescale 1ns/10ps

module alu_execute (
    input  logic                   valid_i,
    input  core_pkg::decoded_t     decoded_i,
    input  core_pkg::rf_write_t    fwd_i,
    output logic                   valid_o,
    output core_pkg::exec_result_t result_o
);

    core_pkg::xlen_t rs1_fwd;
    core_pkg::xlen_t rs2_fwd;
    core_pkg::xlen_t op_a;
    core_pkg::xlen_t op_b;
    core_pkg::xlen_t alu_res;
    logic [4:0]      shamt;

    // ==============================
    // operand forwarding
    // ==============================
    function automatic core_pkg::xlen_t fwd_sel(
        input core_pkg::reg_idx_t  idx,
        input core_pkg::xlen_t     val,
        input core_pkg::rf_write_t wr
    );
        if (wr.en && (wr.idx == idx) && (idx != '0)) begin
            return wr.data;
        end
        return val;
    endfunction

    assign rs1_fwd = fwd_sel(decoded_i.rs1_idx, decoded_i.rs1_val, fwd_i);
    assign rs2_fwd = fwd_sel(decoded_i.rs2_idx, decoded_i.rs2_val, fwd_i);

    // pc for auipc, immediate for the I and U groups
    assign op_a  = decoded_i.use_pc  ? decoded_i.pc  : rs1_fwd;
    assign op_b  = decoded_i.use_imm ? decoded_i.imm : rs2_fwd;
    assign shamt = op_b[4:0];

    // ==============================
    // ALU
    // ==============================
    always_comb begin
        case (decoded_i.alu_op)
            core_pkg::ALU_ADD: begin
                alu_res = op_a + op_b;
            end
            core_pkg::ALU_SUB: begin
                alu_res = op_a - op_b;
            end
            core_pkg::ALU_SLL: begin
                alu_res = op_a << shamt;
            end
            core_pkg::ALU_SLT: begin
                alu_res = core_pkg::xlen_t'($signed(op_a) < $signed(op_b));
            end
            core_pkg::ALU_SLTU: begin
                alu_res = core_pkg::xlen_t'(op_a < op_b);
            end
            core_pkg::ALU_XOR: begin
                alu_res = op_a ^ op_b;
            end
            core_pkg::ALU_SRL: begin
                alu_res = op_a >> shamt;
            end
            core_pkg::ALU_SRA: begin
                alu_res = core_pkg::xlen_t'($signed(op_a) >>> shamt);
            end
            core_pkg::ALU_OR: begin
                alu_res = op_a | op_b;
            end
            core_pkg::ALU_AND: begin
                alu_res = op_a & op_b;
            end
            default: begin
                // lui
                alu_res = op_b;
            end
        endcase
    end

    assign valid_o = valid_i;

    always_comb begin
        result_o          = '0;
        result_o.pc       = decoded_i.pc;
        result_o.rd       = decoded_i.rd;
        result_o.result   = alu_res;
        result_o.write_en = decoded_i.write_en;
        result_o.illegal  = decoded_i.illegal;
    end

endmodule

/* logic/core_pkg.sv */
package core_pkg;

    // ==============================
    // widths and basic types
    // ==============================
    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]              xlen_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

    // ==============================
    // encodings
    // ==============================
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // bit 30 selects sub and sra
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // ==============================
    // pipeline records
    // ==============================
    typedef struct packed {
        xlen_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rs1_idx;
        xlen_t    rs1_val;
        reg_idx_t rs2_idx;
        xlen_t    rs2_val;
        xlen_t    imm;
        logic     use_imm;
        logic     use_pc;
        reg_idx_t rd;
        logic     write_en;
        logic     illegal;
    } decoded_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    result;
        logic     write_en;
        logic     illegal;
    } exec_result_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        xlen_t    data;
    } rf_write_t;

    typedef struct packed {
        logic     en;
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    data;
        logic     illegal;
    } commit_t;

endpackage

/* logic/instr_decode.sv */
`timescale 1ns/10ps

module instr_decode #(
    parameter core_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               instr_valid_i,
    input  core_pkg::xlen_t    instr_i,
    output core_pkg::reg_idx_t rs1_idx_o,
    output core_pkg::reg_idx_t rs2_idx_o,
    input  core_pkg::xlen_t    rs1_data_i,
    input  core_pkg::xlen_t    rs2_data_i,
    output core_pkg::decoded_t decoded_o
);

    core_pkg::xlen_t pc_q;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            bad_funct7;

    // maps funct3 and bit 30 onto an ALU operation
    function automatic core_pkg::alu_op_e map_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       allow_sub
    );
        case (f3)
            core_pkg::F3_ADD_SUB: return (alt && allow_sub) ? core_pkg::ALU_SUB
                                                            : core_pkg::ALU_ADD;
            core_pkg::F3_SLL:     return core_pkg::ALU_SLL;
            core_pkg::F3_SLT:     return core_pkg::ALU_SLT;
            core_pkg::F3_SLTU:    return core_pkg::ALU_SLTU;
            core_pkg::F3_XOR:     return core_pkg::ALU_XOR;
            core_pkg::F3_SRL_SRA: return alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            core_pkg::F3_OR:      return core_pkg::ALU_OR;
            default:              return core_pkg::ALU_AND;
        endcase
    endfunction

    // pc of the next accepted instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_q <= RESET_PC;
        end else if (instr_valid_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign bad_funct7 = (funct7 != core_pkg::F7_BASE) && (funct7 != core_pkg::F7_ALT);

    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];

    always_comb begin
        decoded_o          = '0;
        decoded_o.pc       = pc_q;
        decoded_o.alu_op   = core_pkg::ALU_ADD;
        decoded_o.rs1_idx  = instr_i[19:15];
        decoded_o.rs1_val  = rs1_data_i;
        decoded_o.rs2_idx  = instr_i[24:20];
        decoded_o.rs2_val  = rs2_data_i;
        decoded_o.rd       = instr_i[11:7];
        decoded_o.write_en = 1'b1;

        case (opcode)
            core_pkg::OPC_OP: begin
                decoded_o.alu_op  = map_op(funct3, funct7[5], 1'b1);
                decoded_o.illegal = bad_funct7;
            end
            core_pkg::OPC_OP_IMM: begin
                decoded_o.imm     = {{20{instr_i[31]}}, instr_i[31:20]};
                decoded_o.use_imm = 1'b1;
                decoded_o.alu_op  = map_op(funct3, funct7[5], 1'b0);
                // funct7 only matters for the shifts
                decoded_o.illegal = bad_funct7 && ((funct3 == core_pkg::F3_SLL) ||
                                                   (funct3 == core_pkg::F3_SRL_SRA));
            end
            core_pkg::OPC_LUI: begin
                decoded_o.imm     = {instr_i[31:12], 12'b0};
                decoded_o.use_imm = 1'b1;
                decoded_o.alu_op  = core_pkg::ALU_PASS_B;
            end
            core_pkg::OPC_AUIPC: begin
                decoded_o.imm     = {instr_i[31:12], 12'b0};
                decoded_o.use_imm = 1'b1;
                decoded_o.use_pc  = 1'b1;
            end
            default: begin
                decoded_o.illegal = 1'b1;
            end
        endcase

        if (decoded_o.illegal) begin
            decoded_o.write_en = 1'b0;
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                clk,
    input  logic                resetn,
    input  core_pkg::reg_idx_t  rs1_idx_i,
    input  core_pkg::reg_idx_t  rs2_idx_i,
    output core_pkg::xlen_t     rs1_data_o,
    output core_pkg::xlen_t     rs2_data_o,
    input  core_pkg::rf_write_t write_i
);

    // x0 has no storage
    core_pkg::xlen_t regs_q [1:core_pkg::REG_COUNT-1];

    function automatic core_pkg::xlen_t read_port(input core_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        // same-cycle write goes straight through
        if (write_i.en && (write_i.idx == idx)) begin
            return write_i.data;
        end
        return regs_q[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < core_pkg::REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (write_i.en && (write_i.idx != '0)) begin
            regs_q[write_i.idx] <= write_i.data;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_idx_i);
        rs2_data_o = read_port(rs2_idx_i);
    end

endmodule

/* logic/stage_reg.sv */
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     valid_i,
    input  payload_t payload_i,
    output logic     valid_o,
    output payload_t payload_o
);

    logic     valid_q;
    payload_t payload_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // payload only moves with a valid entry
    always_ff @(posedge clk) begin
        if (valid_i) begin
            payload_q <= payload_i;
        end
    end

    assign valid_o   = valid_q;
    assign payload_o = payload_q;

endmodule

/* logic/write_back.sv */
`timescale 1ns/10ps

module write_back (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   valid_i,
    input  core_pkg::exec_result_t result_i,
    output core_pkg::rf_write_t    rf_write_o,
    output core_pkg::commit_t      commit_o
);

    logic            commit_en_q;
    core_pkg::xlen_t commit_pc_q;
    core_pkg::reg_idx_t commit_rd_q;
    core_pkg::xlen_t commit_data_q;
    logic            commit_illegal_q;

    // register file write port
    assign rf_write_o.en   = valid_i && !result_i.illegal && result_i.write_en &&
                             (result_i.rd != '0);
    assign rf_write_o.idx  = result_i.rd;
    assign rf_write_o.data = result_i.result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            commit_en_q <= 1'b0;
        end else begin
            commit_en_q <= valid_i;
        end
    end

    // illegal words report rd and data as zero, x0 reports data zero
    always_ff @(posedge clk) begin
        if (valid_i) begin
            commit_pc_q      <= result_i.pc;
            commit_rd_q      <= result_i.illegal ? '0 : result_i.rd;
            commit_data_q    <= rf_write_o.en ? result_i.result : '0;
            commit_illegal_q <= result_i.illegal;
        end
    end

    assign commit_o.en      = commit_en_q;
    assign commit_o.pc      = commit_pc_q;
    assign commit_o.rd      = commit_rd_q;
    assign commit_o.data    = commit_data_q;
    assign commit_o.illegal = commit_illegal_q;

endmodule
